// File: logic/lce_cmd_pkg.sv
// LCE command side definitions
package lce_cmd_pkg;

  // cache geometry
  localparam int SETS    = 64;
  localparam int ASSOC   = 4;
  localparam int NUM_CCE = 2;

  localparam int INDEX_W        = $clog2(SETS);
  localparam int WAY_W          = $clog2(ASSOC);
  localparam int PADDR_W        = 22;
  localparam int BLOCK_W        = 64;
  localparam int BLOCK_OFFSET_W = $clog2(BLOCK_W / 8);
  localparam int PTAG_W         = PADDR_W - INDEX_W - BLOCK_OFFSET_W;

  localparam int LCE_ID_W = 2;
  localparam int CCE_ID_W = 1;

  // counters
  localparam int SWEEP_CNT_W = INDEX_W;
  localparam int SYNC_CNT_W  = 2;

  typedef enum logic [2:0] {
    coh_i = 3'd0,
    coh_s = 3'd1,
    coh_e = 3'd2,
    coh_f = 3'd3,
    coh_m = 3'd4,
    coh_o = 3'd5
  } coh_state_e;

  // cmd_tr is decoded but never consumed
  typedef enum logic [3:0] {
    cmd_sync      = 4'd0,
    cmd_set_clear = 4'd1,
    cmd_st        = 4'd2,
    cmd_st_wakeup = 4'd3,
    cmd_inv       = 4'd4,
    cmd_wb        = 4'd5,
    cmd_data      = 4'd6,
    cmd_uc_data   = 4'd7,
    cmd_tr        = 4'd8
  } lce_cmd_type_e;

  typedef enum logic [1:0] {
    resp_sync_ack = 2'd0,
    resp_inv_ack  = 2'd1,
    resp_null_wb  = 2'd2
  } lce_resp_type_e;

  typedef enum logic [1:0] {
    tag_set_clear  = 2'd0,
    tag_set_tag    = 2'd1,
    tag_invalidate = 2'd2
  } tag_op_e;

  typedef enum logic {
    stat_set_clear = 1'b0
  } stat_op_e;

  typedef enum logic {
    data_write    = 1'b0,
    data_uncached = 1'b1
  } data_op_e;

  // set index sits just above the block offset
  function automatic logic [INDEX_W-1:0] addr_index(input logic [PADDR_W-1:0] addr);
    return addr[BLOCK_OFFSET_W +: INDEX_W];
  endfunction

  function automatic logic [PTAG_W-1:0] addr_tag(input logic [PADDR_W-1:0] addr);
    return addr[BLOCK_OFFSET_W + INDEX_W +: PTAG_W];
  endfunction

endpackage

// File: logic/tag_stat_pkt_if.sv
// Tag and status packet interface
interface tag_stat_pkt_if;
  import lce_cmd_pkg::*;

  // tag memory packet
  logic               tag_v;
  logic               tag_ready;
  logic [INDEX_W-1:0] tag_index;
  logic [WAY_W-1:0]   tag_way;
  coh_state_e         tag_state;
  logic [PTAG_W-1:0]  tag_ptag;
  tag_op_e            tag_op;

  // status memory packet
  logic               stat_v;
  logic               stat_ready;
  logic [INDEX_W-1:0] stat_index;
  stat_op_e           stat_op;

  modport source (
    output tag_v, tag_index, tag_way, tag_state, tag_ptag, tag_op,
    output stat_v, stat_index, stat_op,
    input  tag_ready, stat_ready
  );

  modport sink (
    input  tag_v, tag_index, tag_way, tag_state, tag_ptag, tag_op,
    input  stat_v, stat_index, stat_op,
    output tag_ready, stat_ready
  );

endinterface

// File: logic/lce_set_sweep.sv
// Post-reset set clear sweep
module lce_set_sweep (
  input  logic            clk_i,
  input  logic            reset_i,
  tag_stat_pkt_if.sink    fsm_pkt,
  tag_stat_pkt_if.source  mem_pkt,
  output logic            sweep_done_o
);
  import lce_cmd_pkg::*;

  logic [SWEEP_CNT_W-1:0] sweep_cnt_r;
  logic                   done_r;
  logic                   sweep_fire;

  // one tag and one status clear per cycle when both memories accept
  assign sweep_fire = ~done_r & mem_pkt.tag_ready & mem_pkt.stat_ready;

  always_comb begin
    if (done_r) begin
      mem_pkt.tag_v      = fsm_pkt.tag_v;
      mem_pkt.tag_index  = fsm_pkt.tag_index;
      mem_pkt.tag_way    = fsm_pkt.tag_way;
      mem_pkt.tag_state  = fsm_pkt.tag_state;
      mem_pkt.tag_ptag   = fsm_pkt.tag_ptag;
      mem_pkt.tag_op     = fsm_pkt.tag_op;
      mem_pkt.stat_v     = fsm_pkt.stat_v;
      mem_pkt.stat_index = fsm_pkt.stat_index;
      mem_pkt.stat_op    = fsm_pkt.stat_op;
      fsm_pkt.tag_ready  = mem_pkt.tag_ready;
      fsm_pkt.stat_ready = mem_pkt.stat_ready;
    end else begin
      mem_pkt.tag_v      = sweep_fire;
      mem_pkt.tag_index  = sweep_cnt_r;
      mem_pkt.tag_way    = '0;
      mem_pkt.tag_state  = coh_i;
      mem_pkt.tag_ptag   = '0;
      mem_pkt.tag_op     = tag_set_clear;
      mem_pkt.stat_v     = sweep_fire;
      mem_pkt.stat_index = sweep_cnt_r;
      mem_pkt.stat_op    = stat_set_clear;
      // command path sees no room until the sweep is over
      fsm_pkt.tag_ready  = 1'b0;
      fsm_pkt.stat_ready = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sweep_cnt_r <= '0;
      done_r      <= 1'b0;
    end else if (sweep_fire) begin
      sweep_cnt_r <= sweep_cnt_r + 1'b1;
      if (sweep_cnt_r == SWEEP_CNT_W'(SETS - 1)) begin
        done_r <= 1'b1;
      end
    end
  end

  assign sweep_done_o = done_r;

endmodule

// File: logic/lce_cmd_fsm.sv
// LCE command decoder FSM
module lce_cmd_fsm (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 sweep_done_i,
  input  logic [lce_cmd_pkg::LCE_ID_W-1:0]     lce_id_i,
  input  logic [lce_cmd_pkg::PADDR_W-1:0]      miss_addr_i,

  input  logic                                 cmd_v_i,
  input  lce_cmd_pkg::lce_cmd_type_e           cmd_type_i,
  input  logic [lce_cmd_pkg::PADDR_W-1:0]      cmd_addr_i,
  input  logic [lce_cmd_pkg::CCE_ID_W-1:0]     cmd_src_i,
  input  logic [lce_cmd_pkg::WAY_W-1:0]        cmd_way_i,
  input  lce_cmd_pkg::coh_state_e              cmd_state_i,
  input  logic [lce_cmd_pkg::BLOCK_W-1:0]      cmd_data_i,
  output logic                                 cmd_yumi_o,

  output logic                                 resp_v_o,
  output lce_cmd_pkg::lce_resp_type_e          resp_type_o,
  output logic [lce_cmd_pkg::CCE_ID_W-1:0]     resp_dst_o,
  output logic [lce_cmd_pkg::LCE_ID_W-1:0]     resp_src_o,
  output logic [lce_cmd_pkg::PADDR_W-1:0]      resp_addr_o,
  input  logic                                 resp_yumi_i,

  output logic                                 data_v_o,
  output logic [lce_cmd_pkg::INDEX_W-1:0]      data_index_o,
  output logic [lce_cmd_pkg::WAY_W-1:0]        data_way_o,
  output logic [lce_cmd_pkg::BLOCK_W-1:0]      data_o,
  output lce_cmd_pkg::data_op_e                data_op_o,
  input  logic                                 data_ready_i,

  tag_stat_pkt_if.source                       pkt,

  output logic                                 lce_ready_o,
  output logic                                 set_tag_received_o,
  output logic                                 set_tag_wakeup_received_o,
  output logic                                 cce_data_received_o,
  output logic                                 uncached_data_received_o,
  output logic                                 cache_req_complete_o
);
  import lce_cmd_pkg::*;

  typedef enum logic [1:0] {
    st_reset,
    st_uncached_only,
    st_ready
  } lce_cmd_state_e;

  lce_cmd_state_e          state_r, state_n;
  logic [SYNC_CNT_W-1:0]   sync_cnt_r, sync_cnt_n;
  logic                    inv_flag_r, inv_flag_n;
  logic                    in_ready;
  logic                    clear_fire;
  logic                    fill_fire;
  logic [INDEX_W-1:0]      cmd_index;
  logic [INDEX_W-1:0]      miss_index;

  assign in_ready   = (state_r == st_ready);
  assign cmd_index  = addr_index(cmd_addr_i);
  assign miss_index = addr_index(miss_addr_i);
  assign clear_fire = pkt.tag_ready & pkt.stat_ready;
  assign fill_fire  = pkt.tag_ready & data_ready_i;

  // response header follows the command directly
  assign resp_dst_o  = cmd_src_i;
  assign resp_src_o  = lce_id_i;
  assign resp_addr_o = cmd_addr_i;

  // data fill and uncached data land in the set of the outstanding miss
  assign data_index_o = miss_index;
  assign data_way_o   = cmd_way_i;
  assign data_o       = cmd_data_i;

  assign lce_ready_o = sweep_done_i;

  always_comb begin
    state_n    = state_r;
    sync_cnt_n = sync_cnt_r;
    inv_flag_n = inv_flag_r;

    cmd_yumi_o  = 1'b0;
    resp_v_o    = 1'b0;
    resp_type_o = resp_sync_ack;
    data_v_o    = 1'b0;
    data_op_o   = data_write;

    pkt.tag_v      = 1'b0;
    pkt.tag_index  = cmd_index;
    pkt.tag_way    = cmd_way_i;
    pkt.tag_state  = coh_i;
    pkt.tag_ptag   = '0;
    pkt.tag_op     = tag_set_clear;
    pkt.stat_v     = 1'b0;
    pkt.stat_index = cmd_index;
    pkt.stat_op    = stat_set_clear;

    set_tag_received_o        = 1'b0;
    set_tag_wakeup_received_o = 1'b0;
    cce_data_received_o       = 1'b0;
    uncached_data_received_o  = 1'b0;
    cache_req_complete_o      = 1'b0;

    case (state_r)
      st_reset: begin
        if (sweep_done_i) begin
          state_n = st_uncached_only;
        end
      end

      st_uncached_only, st_ready: begin
        if (cmd_v_i) begin
          case (cmd_type_i)
            cmd_set_clear: begin
              pkt.tag_v  = clear_fire;
              pkt.stat_v = clear_fire;
              cmd_yumi_o = clear_fire;
            end

            cmd_sync: begin
              if (!in_ready) begin
                resp_v_o   = 1'b1;
                cmd_yumi_o = resp_yumi_i;
                if (resp_yumi_i) begin
                  if (sync_cnt_r == SYNC_CNT_W'(NUM_CCE - 1)) begin
                    sync_cnt_n = '0;
                    state_n    = st_ready;
                  end else begin
                    sync_cnt_n = sync_cnt_r + 1'b1;
                  end
                end
              end
            end

            cmd_uc_data: begin
              data_v_o                 = data_ready_i;
              data_op_o                = data_uncached;
              cmd_yumi_o               = data_ready_i;
              uncached_data_received_o = data_ready_i;
              cache_req_complete_o     = data_ready_i;
            end

            cmd_st, cmd_st_wakeup: begin
              if (in_ready) begin
                pkt.tag_v     = pkt.tag_ready;
                pkt.tag_state = cmd_state_i;
                pkt.tag_ptag  = addr_tag(cmd_addr_i);
                pkt.tag_op    = tag_set_tag;
                cmd_yumi_o    = pkt.tag_ready;
                if (cmd_type_i == cmd_st_wakeup) begin
                  set_tag_wakeup_received_o = pkt.tag_ready;
                  cache_req_complete_o      = pkt.tag_ready;
                end else begin
                  set_tag_received_o = pkt.tag_ready;
                end
              end
            end

            cmd_inv: begin
              if (in_ready) begin
                // tag invalidate goes out once and then the ack waits on yumi
                pkt.tag_v   = pkt.tag_ready & ~inv_flag_r;
                pkt.tag_op  = tag_invalidate;
                resp_v_o    = inv_flag_r | pkt.tag_v;
                resp_type_o = resp_inv_ack;
                cmd_yumi_o  = resp_v_o & resp_yumi_i;
                inv_flag_n  = resp_yumi_i ? 1'b0 : resp_v_o;
              end
            end

            cmd_wb: begin
              if (in_ready) begin
                resp_v_o    = 1'b1;
                resp_type_o = resp_null_wb;
                cmd_yumi_o  = resp_yumi_i;
              end
            end

            cmd_data: begin
              if (in_ready) begin
                data_v_o             = fill_fire;
                pkt.tag_v            = fill_fire;
                pkt.tag_index        = miss_index;
                pkt.tag_state        = cmd_state_i;
                pkt.tag_ptag         = addr_tag(cmd_addr_i);
                pkt.tag_op           = tag_set_tag;
                cmd_yumi_o           = fill_fire;
                cce_data_received_o  = fill_fire;
                set_tag_received_o   = fill_fire;
                cache_req_complete_o = fill_fire;
              end
            end

            default: begin
            end
          endcase
        end
      end

      default: begin
        state_n = st_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= st_reset;
      sync_cnt_r <= '0;
      inv_flag_r <= 1'b0;
    end else begin
      state_r    <= state_n;
      sync_cnt_r <= sync_cnt_n;
      inv_flag_r <= inv_flag_n;
    end
  end

endmodule

// File: logic/lce_cmd_unit.sv
// LCE command unit top
module lce_cmd_unit (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic [lce_cmd_pkg::LCE_ID_W-1:0]     lce_id_i,
  input  logic [lce_cmd_pkg::PADDR_W-1:0]      miss_addr_i,

  input  logic                                 cmd_v_i,
  input  lce_cmd_pkg::lce_cmd_type_e           cmd_type_i,
  input  logic [lce_cmd_pkg::PADDR_W-1:0]      cmd_addr_i,
  input  logic [lce_cmd_pkg::CCE_ID_W-1:0]     cmd_src_i,
  input  logic [lce_cmd_pkg::WAY_W-1:0]        cmd_way_i,
  input  lce_cmd_pkg::coh_state_e              cmd_state_i,
  input  logic [lce_cmd_pkg::BLOCK_W-1:0]      cmd_data_i,
  output logic                                 cmd_yumi_o,

  output logic                                 resp_v_o,
  output lce_cmd_pkg::lce_resp_type_e          resp_type_o,
  output logic [lce_cmd_pkg::CCE_ID_W-1:0]     resp_dst_o,
  output logic [lce_cmd_pkg::LCE_ID_W-1:0]     resp_src_o,
  output logic [lce_cmd_pkg::PADDR_W-1:0]      resp_addr_o,
  input  logic                                 resp_yumi_i,

  output logic                                 data_v_o,
  output logic [lce_cmd_pkg::INDEX_W-1:0]      data_index_o,
  output logic [lce_cmd_pkg::WAY_W-1:0]        data_way_o,
  output logic [lce_cmd_pkg::BLOCK_W-1:0]      data_o,
  output lce_cmd_pkg::data_op_e                data_op_o,
  input  logic                                 data_ready_i,

  output logic                                 tag_v_o,
  input  logic                                 tag_ready_i,
  output logic [lce_cmd_pkg::INDEX_W-1:0]      tag_index_o,
  output logic [lce_cmd_pkg::WAY_W-1:0]        tag_way_o,
  output lce_cmd_pkg::coh_state_e              tag_state_o,
  output logic [lce_cmd_pkg::PTAG_W-1:0]       tag_ptag_o,
  output lce_cmd_pkg::tag_op_e                 tag_op_o,

  output logic                                 stat_v_o,
  input  logic                                 stat_ready_i,
  output logic [lce_cmd_pkg::INDEX_W-1:0]      stat_index_o,
  output lce_cmd_pkg::stat_op_e                stat_op_o,

  output logic                                 lce_ready_o,
  output logic                                 set_tag_received_o,
  output logic                                 set_tag_wakeup_received_o,
  output logic                                 cce_data_received_o,
  output logic                                 uncached_data_received_o,
  output logic                                 cache_req_complete_o
);

  logic sweep_done;

  tag_stat_pkt_if fsm_pkt ();
  tag_stat_pkt_if mem_pkt ();

  // memory side packets map onto plain ports
  assign tag_v_o            = mem_pkt.tag_v;
  assign tag_index_o        = mem_pkt.tag_index;
  assign tag_way_o          = mem_pkt.tag_way;
  assign tag_state_o        = mem_pkt.tag_state;
  assign tag_ptag_o         = mem_pkt.tag_ptag;
  assign tag_op_o           = mem_pkt.tag_op;
  assign stat_v_o           = mem_pkt.stat_v;
  assign stat_index_o       = mem_pkt.stat_index;
  assign stat_op_o          = mem_pkt.stat_op;
  assign mem_pkt.tag_ready  = tag_ready_i;
  assign mem_pkt.stat_ready = stat_ready_i;

  lce_set_sweep u_sweep (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .fsm_pkt      (fsm_pkt.sink),
    .mem_pkt      (mem_pkt.source),
    .sweep_done_o (sweep_done)
  );

  lce_cmd_fsm u_fsm (
    .clk_i                     (clk_i),
    .reset_i                   (reset_i),
    .sweep_done_i              (sweep_done),
    .lce_id_i                  (lce_id_i),
    .miss_addr_i               (miss_addr_i),
    .cmd_v_i                   (cmd_v_i),
    .cmd_type_i                (cmd_type_i),
    .cmd_addr_i                (cmd_addr_i),
    .cmd_src_i                 (cmd_src_i),
    .cmd_way_i                 (cmd_way_i),
    .cmd_state_i               (cmd_state_i),
    .cmd_data_i                (cmd_data_i),
    .cmd_yumi_o                (cmd_yumi_o),
    .resp_v_o                  (resp_v_o),
    .resp_type_o               (resp_type_o),
    .resp_dst_o                (resp_dst_o),
    .resp_src_o                (resp_src_o),
    .resp_addr_o               (resp_addr_o),
    .resp_yumi_i               (resp_yumi_i),
    .data_v_o                  (data_v_o),
    .data_index_o              (data_index_o),
    .data_way_o                (data_way_o),
    .data_o                    (data_o),
    .data_op_o                 (data_op_o),
    .data_ready_i              (data_ready_i),
    .pkt                       (fsm_pkt.source),
    .lce_ready_o               (lce_ready_o),
    .set_tag_received_o        (set_tag_received_o),
    .set_tag_wakeup_received_o (set_tag_wakeup_received_o),
    .cce_data_received_o       (cce_data_received_o),
    .uncached_data_received_o  (uncached_data_received_o),
    .cache_req_complete_o      (cache_req_complete_o)
  );

endmodule

// File: bench/lce_cmd_tb.sv
// LCE command unit testbench
module lce_cmd_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import lce_cmd_pkg::*;

  localparam int NCOLS         = 19;
  localparam int NTESTS        = 14;
  localparam int CMD_TIMEOUT   = 200;
  localparam int HOLD_CYCLES   = 20;
  localparam int SWEEP_TIMEOUT = SETS * 20;
  localparam logic [LCE_ID_W-1:0] MY_LCE_ID = 2'd1;

  logic                clk_i;
  logic                reset_i;
  logic [LCE_ID_W-1:0] lce_id_i;
  logic [PADDR_W-1:0]  miss_addr_i;
  logic                cmd_v_i;
  lce_cmd_type_e       cmd_type_i;
  logic [PADDR_W-1:0]  cmd_addr_i;
  logic [CCE_ID_W-1:0] cmd_src_i;
  logic [WAY_W-1:0]    cmd_way_i;
  coh_state_e          cmd_state_i;
  logic [BLOCK_W-1:0]  cmd_data_i;
  logic                cmd_yumi_o;
  logic                resp_v_o;
  lce_resp_type_e      resp_type_o;
  logic [CCE_ID_W-1:0] resp_dst_o;
  logic [LCE_ID_W-1:0] resp_src_o;
  logic [PADDR_W-1:0]  resp_addr_o;
  logic                resp_yumi_i;
  logic                data_v_o;
  logic [INDEX_W-1:0]  data_index_o;
  logic [WAY_W-1:0]    data_way_o;
  logic [BLOCK_W-1:0]  data_o;
  data_op_e            data_op_o;
  logic                data_ready_i;
  logic                tag_v_o;
  logic                tag_ready_i;
  logic [INDEX_W-1:0]  tag_index_o;
  logic [WAY_W-1:0]    tag_way_o;
  coh_state_e          tag_state_o;
  logic [PTAG_W-1:0]   tag_ptag_o;
  tag_op_e             tag_op_o;
  logic                stat_v_o;
  logic                stat_ready_i;
  logic [INDEX_W-1:0]  stat_index_o;
  stat_op_e            stat_op_o;
  logic                lce_ready_o;
  logic                set_tag_received_o;
  logic                set_tag_wakeup_received_o;
  logic                cce_data_received_o;
  logic                uncached_data_received_o;
  logic                cache_req_complete_o;

  logic [63:0] tdata [0:NTESTS*NCOLS-1];
  int unsigned lcg_state;
  string       test_name;
  int          err_cnt;
  int          pass_cnt;
  int          fail_cnt;

  lce_cmd_unit uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic int unsigned lcg_next(input int unsigned s);
    return (s * 32'd1103515245 + 32'd12345) & 32'h7fffffff;
  endfunction

  function automatic string cmd_name(input logic [3:0] code);
    case (code)
      4'd0: return "sync";
      4'd1: return "set_clear";
      4'd2: return "set_tag";
      4'd3: return "set_tag_wakeup";
      4'd4: return "invalidate";
      4'd5: return "writeback";
      4'd6: return "data_fill";
      4'd7: return "uncached_data";
      default: return "transfer";
    endcase
  endfunction

  // memory readiness and response yumi are each low about a quarter of the time
  initial begin
    lcg_state    = 15;
    tag_ready_i  = 1'b0;
    stat_ready_i = 1'b0;
    data_ready_i = 1'b0;
    resp_yumi_i  = 1'b0;
    forever begin
      @(posedge clk_i);
      #10;
      lcg_state    = lcg_next(lcg_state);
      tag_ready_i  = lcg_state[17:16] != 2'b00;
      stat_ready_i = lcg_state[19:18] != 2'b00;
      data_ready_i = lcg_state[21:20] != 2'b00;
      resp_yumi_i  = lcg_state[23:22] != 2'b00;
    end
  end

  task automatic report_mismatch(input string what, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
    $display("Error %s: %s expected %0h actual %0h", test_name, what, exp_val, act_val);
    err_cnt++;
  endtask

  task automatic close_test(input int err_before);
    if (err_cnt == err_before) begin
      pass_cnt++;
      $display("test %s passed", test_name);
    end else begin
      fail_cnt++;
      $display("test %s failed", test_name);
    end
  endtask

  task automatic check_sweep();
    int cyc;
    int tag_cnt;
    int stat_cnt;
    int err_before;
    test_name  = "reset_sweep";
    err_before = err_cnt;
    tag_cnt    = 0;
    stat_cnt   = 0;
    cyc        = 0;
    while (!lce_ready_o && cyc < SWEEP_TIMEOUT) begin
      @(negedge clk_i);
      cyc++;
      if (!lce_ready_o && tag_v_o && tag_ready_i) begin
        if (tag_op_o !== tag_set_clear)
          report_mismatch("tag op", tag_set_clear, tag_op_o);
        if (tag_index_o !== tag_cnt)
          report_mismatch("tag index", tag_cnt, tag_index_o);
        tag_cnt++;
      end
      if (!lce_ready_o && stat_v_o && stat_ready_i) begin
        if (stat_op_o !== stat_set_clear)
          report_mismatch("status op", stat_set_clear, stat_op_o);
        if (stat_index_o !== stat_cnt)
          report_mismatch("status index", stat_cnt, stat_index_o);
        stat_cnt++;
      end
    end
    if (!lce_ready_o) begin
      $display("Error %s: lce_ready_o did not rise within %0d cycles", test_name, cyc);
      err_cnt++;
    end
    if (tag_cnt != SETS)
      report_mismatch("tag clears", SETS, tag_cnt);
    if (stat_cnt != SETS)
      report_mismatch("status clears", SETS, stat_cnt);
    close_test(err_before);
  endtask

  // drive one line of the data file and watch every handshake until consumed
  task automatic run_test(input int t);
    int         b;
    int         cyc;
    int         limit;
    int         err_before;
    int         tag_cnt;
    int         stat_cnt;
    int         data_cnt;
    int         resp_cnt;
    bit         consumed;
    logic [4:0] pulses;
    b          = t * NCOLS;
    test_name  = $sformatf("%0d_%s", t, cmd_name(tdata[b][3:0]));
    err_before = err_cnt;
    tag_cnt    = 0;
    stat_cnt   = 0;
    data_cnt   = 0;
    resp_cnt   = 0;
    consumed   = 1'b0;
    cyc        = 0;
    limit      = (tdata[b+7] == 0) ? HOLD_CYCLES : CMD_TIMEOUT;
    @(posedge clk_i);
    #10;
    cmd_type_i  = lce_cmd_type_e'(tdata[b][3:0]);
    cmd_src_i   = tdata[b+1][CCE_ID_W-1:0];
    cmd_way_i   = tdata[b+2][WAY_W-1:0];
    cmd_state_i = coh_state_e'(tdata[b+3][2:0]);
    cmd_addr_i  = tdata[b+4][PADDR_W-1:0];
    miss_addr_i = tdata[b+5][PADDR_W-1:0];
    cmd_data_i  = tdata[b+6];
    cmd_v_i     = 1'b1;
    while (!consumed && cyc < limit) begin
      @(negedge clk_i);
      cyc++;
      pulses = {set_tag_received_o, set_tag_wakeup_received_o, cce_data_received_o,
                uncached_data_received_o, cache_req_complete_o};
      if (tag_v_o && tag_ready_i) begin
        tag_cnt++;
        if (tag_op_o !== tdata[b+9][1:0])
          report_mismatch("tag op", tdata[b+9], tag_op_o);
        if (tag_index_o !== tdata[b+10][INDEX_W-1:0])
          report_mismatch("tag index", tdata[b+10], tag_index_o);
        if (tag_ptag_o !== tdata[b+11][PTAG_W-1:0])
          report_mismatch("tag ptag", tdata[b+11], tag_ptag_o);
        if (tag_way_o !== cmd_way_i)
          report_mismatch("tag way", cmd_way_i, tag_way_o);
        if (tag_state_o !== cmd_state_i)
          report_mismatch("tag state", cmd_state_i, tag_state_o);
      end
      if (stat_v_o && stat_ready_i) begin
        stat_cnt++;
        if (stat_op_o !== stat_set_clear)
          report_mismatch("status op", stat_set_clear, stat_op_o);
        if (stat_index_o !== tdata[b+10][INDEX_W-1:0])
          report_mismatch("status index", tdata[b+10], stat_index_o);
      end
      if (data_v_o && data_ready_i) begin
        data_cnt++;
        if (data_op_o !== tdata[b+14][0])
          report_mismatch("data op", tdata[b+14], data_op_o);
        if (data_index_o !== tdata[b+15][INDEX_W-1:0])
          report_mismatch("data index", tdata[b+15], data_index_o);
        if (data_o !== cmd_data_i)
          report_mismatch("data", cmd_data_i, data_o);
        if (data_way_o !== cmd_way_i)
          report_mismatch("data way", cmd_way_i, data_way_o);
      end
      if (resp_v_o && resp_yumi_i) begin
        resp_cnt++;
        if (resp_type_o !== tdata[b+17][1:0])
          report_mismatch("resp type", tdata[b+17], resp_type_o);
        if (resp_dst_o !== cmd_src_i)
          report_mismatch("resp dst", cmd_src_i, resp_dst_o);
        if (resp_src_o !== MY_LCE_ID)
          report_mismatch("resp src", MY_LCE_ID, resp_src_o);
        if (resp_addr_o !== cmd_addr_i)
          report_mismatch("resp addr", cmd_addr_i, resp_addr_o);
      end
      if (cmd_yumi_o) begin
        consumed = 1'b1;
        if (pulses !== tdata[b+18][4:0])
          report_mismatch("pulses", tdata[b+18], pulses);
      end else if (pulses !== 5'b0) begin
        $display("Error %s: notification pulse without command consumption", test_name);
        err_cnt++;
      end
    end
    @(posedge clk_i);
    #10;
    cmd_v_i = 1'b0;
    if (tdata[b+7] != 0 && !consumed) begin
      $display("Error %s: command not consumed within %0d cycles", test_name, limit);
      err_cnt++;
    end
    if (tdata[b+7] == 0 && consumed) begin
      $display("Error %s: command consumed although it should stall", test_name);
      err_cnt++;
    end
    if (tag_cnt != tdata[b+8])
      report_mismatch("tag packets", tdata[b+8], tag_cnt);
    if (stat_cnt != tdata[b+12])
      report_mismatch("status packets", tdata[b+12], stat_cnt);
    if (data_cnt != tdata[b+13])
      report_mismatch("data packets", tdata[b+13], data_cnt);
    if (resp_cnt != tdata[b+16])
      report_mismatch("responses", tdata[b+16], resp_cnt);
    close_test(err_before);
  endtask

  initial begin
    reset_i     = 1'b1;
    lce_id_i    = MY_LCE_ID;
    miss_addr_i = '0;
    cmd_v_i     = 1'b0;
    cmd_type_i  = cmd_sync;
    cmd_addr_i  = '0;
    cmd_src_i   = '0;
    cmd_way_i   = '0;
    cmd_state_i = coh_i;
    cmd_data_i  = '0;
    err_cnt     = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    $readmemh("bench/lce_cmd_testdata.txt", tdata);
    repeat (5) @(posedge clk_i);
    #10;
    reset_i = 1'b0;
    check_sweep();
    for (int t = 0; t < NTESTS; t++) begin
      run_test(t);
    end
    $display("tests passed %0d failed %0d errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: bench/lce_cmd_testdata.txt
// type src way state cmd_addr miss_addr data | consume tag_n tag_op tag_idx tag_ptag
// stat_n data_n data_op data_idx resp_n resp_type pulses{st,st_wakeup,cce,uc,complete}

// uncached only mode, before both syncs
7 0 1 0 3fffff 014a90 0123456789abcdef 1 0 0 00 0000 0 1 1 12 0 0 03
2 0 3 2 0eeff8 014a90 0000000000000000 0 0 0 00 0000 0 0 0 00 0 0 00
0 0 0 0 000000 014a90 0000000000000000 1 0 0 00 0000 0 0 0 00 1 0 00
2 0 3 2 0eeff8 014a90 0000000000000000 0 0 0 00 0000 0 0 0 00 0 0 00
0 1 0 0 000000 014a90 0000000000000000 1 0 0 00 0000 0 0 0 00 1 0 00

// ready mode
2 0 3 2 0eeff8 014a90 0000000000000000 1 1 1 3f 0777 0 0 0 00 0 0 10
3 1 2 4 357808 014a90 0000000000000000 1 1 1 01 1abc 0 0 0 00 0 0 09
6 0 1 3 246968 014a90 fedcba9876543210 1 1 1 12 1234 0 1 0 12 0 0 15
4 1 2 0 008500 014a90 0000000000000000 1 1 2 20 0000 0 0 0 00 1 1 00
5 0 0 0 013370 014a90 0000000000000000 1 0 0 00 0000 0 0 0 00 1 2 00
1 0 0 0 000028 014a90 0000000000000000 1 1 0 05 0000 1 0 0 00 0 0 00

// transfer is never consumed
8 0 0 0 000000 014a90 0000000000000000 0 0 0 00 0000 0 0 0 00 0 0 00

// second invalidate and writeback
4 0 3 0 3ffffb 014a90 0000000000000000 1 1 2 3f 0000 0 0 0 00 1 1 00
5 1 1 0 2aaaa8 014a90 0000000000000000 1 0 0 00 0000 0 0 0 00 1 2 00

// File: build.f
logic/lce_cmd_pkg.sv
logic/tag_stat_pkt_if.sv
logic/lce_set_sweep.sv
logic/lce_cmd_fsm.sv
logic/lce_cmd_unit.sv
bench/lce_cmd_tb.sv

// File: Bender.yml
package:
  name: lce_cmd

sources:
  - logic/lce_cmd_pkg.sv
  - logic/tag_stat_pkt_if.sv
  - logic/lce_set_sweep.sv
  - logic/lce_cmd_fsm.sv
  - logic/lce_cmd_unit.sv
  - target: test
    files:
      - bench/lce_cmd_tb.sv
